/* Bender.yml */
package:
  name: fb_sys

sources:
  - files:
      - design/axi_rd_pkg.sv
      - design/fb_cfg_pkg.sv
      - design/fb_burst_reader.sv
      - design/fb_line_fifo.sv
      - design/fb_pix_unpack.sv
      - design/axi_rd_mem.sv
      - design/fb_sys.sv
  - target: test
    files:
      - verification/fb_sys_props.sv
      - verification/fb_sys_tb.sv

/* design/axi_rd_mem.sv */
`timescale 1ns/1ps

module axi_rd_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi_rd_pkg::mem_load_t load,
  input  logic                  ar_valid,
  input  axi_rd_pkg::axi_ar_t   ar,
  output logic                  ar_ready,
  output logic                  r_valid,
  output axi_rd_pkg::axi_r_t    r,
  input  logic                  r_ready
);
  import axi_rd_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_DATA
  } state_t;

  logic [AXI_DATA_WIDTH-1:0] mem [2**(AXI_ADDR_WIDTH-1)];
  state_t                    state;
  logic [AXI_ADDR_WIDTH-2:0] addr;
  logic [7:0]                len;
  logic [7:0]                beat;
  logic [AXI_ID_WIDTH-1:0]   id_q;
  logic [AXI_DATA_WIDTH-1:0] data_q;
  logic                      last_q;

  assign ar_ready = (state == S_IDLE);

  always_ff @(posedge clk) begin
    if (load.we) begin
      mem[load.addr] <= load.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      r_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (ar_valid) state <= S_WAIT;
        S_WAIT: begin
          r_valid <= 1'b1;  // First beat two cycles after AR.
          state   <= S_DATA;
        end
        S_DATA: if (r_ready && last_q) begin
          r_valid <= 1'b0;
          state   <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Burst context and read data.
  always_ff @(posedge clk) begin
    if (state == S_IDLE && ar_valid) begin
      addr <= ar.addr[AXI_ADDR_WIDTH-1:1];
      len  <= ar.len;
      id_q <= ar.id;
      beat <= '0;
    end else if (state == S_WAIT) begin
      data_q <= mem[addr];
      last_q <= (len == 8'd0);
    end else if (state == S_DATA && r_ready && !last_q) begin
      addr   <= addr + 1'b1;
      beat   <= beat + 8'd1;
      data_q <= mem[addr + 1'b1];
      last_q <= (beat + 8'd1 == len);
    end
  end

  assign r.id   = id_q;
  assign r.data = data_q;
  assign r.resp = AXI_RESP_OKAY;
  assign r.last = last_q;

endmodule

/* design/axi_rd_pkg.sv */
package axi_rd_pkg;

  localparam int AXI_ADDR_WIDTH = 20;
  localparam int AXI_DATA_WIDTH = 16;
  localparam int AXI_ID_WIDTH   = 4;
  localparam int BURST_LEN      = 128;

  localparam logic [2:0] AXI_SIZE_2B    = 3'd1;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                len;   // Beats minus one.
    logic [2:0]                size;
    logic [1:0]                burst;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ID_WIDTH-1:0]   id;
    logic [AXI_DATA_WIDTH-1:0] data;
    logic [1:0]                resp;
    logic                      last;
  } axi_r_t;

  typedef struct packed {
    logic                      we;
    logic [AXI_ADDR_WIDTH-2:0] addr;  // Word address.
    logic [AXI_DATA_WIDTH-1:0] data;
  } mem_load_t;

endpackage

/* design/fb_burst_reader.sv */
`timescale 1ns/1ps

module fb_burst_reader (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable,
  input  fb_cfg_pkg::fb_geom_t geom,
  output logic                 ar_valid,
  output axi_rd_pkg::axi_ar_t  ar,
  input  logic                 ar_ready,
  input  logic                 pop
);
  import fb_cfg_pkg::*;
  import axi_rd_pkg::*;

  logic [PIX_IDX_WIDTH-1:0]  pix_idx;
  logic [PIX_IDX_WIDTH-1:0]  pix_next;
  logic [PIX_IDX_WIDTH-1:0]  frame_pix;
  logic [COUNT_WIDTH-1:0]    credit;
  logic [AXI_ADDR_WIDTH-1:0] addr_q;
  logic                      ar_hs;
  logic                      can_issue;

  assign frame_pix = geom.h_visible * geom.v_visible;
  assign pix_next  = pix_idx + PIX_IDX_WIDTH'(BURST_LEN);
  assign ar_hs     = ar_valid && ar_ready;

  // Whole burst must fit in the FIFO.
  assign can_issue = enable && !ar_valid && (credit >= COUNT_WIDTH'(BURST_LEN));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ar_valid <= 1'b0;
    end else if (can_issue) begin
      ar_valid <= 1'b1;
    end else if (ar_hs) begin
      ar_valid <= 1'b0;
    end
  end

  // Held until accepted.
  always_ff @(posedge clk) begin
    if (can_issue) begin
      addr_q <= geom.base + AXI_ADDR_WIDTH'({pix_idx, 1'b0});
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_idx <= '0;
    end else if (ar_hs) begin
      if (pix_next >= frame_pix) begin
        pix_idx <= '0;  // Wrap to base.
      end else begin
        pix_idx <= pix_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit <= COUNT_WIDTH'(FIFO_DEPTH);
    end else begin
      credit <= credit + COUNT_WIDTH'(pop)
              - (ar_hs ? COUNT_WIDTH'(BURST_LEN) : COUNT_WIDTH'(0));
    end
  end

  assign ar.id    = '0;
  assign ar.addr  = addr_q;
  assign ar.len   = 8'(BURST_LEN - 1);
  assign ar.size  = AXI_SIZE_2B;
  assign ar.burst = AXI_BURST_INCR;

endmodule

/* design/fb_cfg_pkg.sv */
package fb_cfg_pkg;

  localparam int COLOR_WIDTH = 4;
  localparam int H_WIDTH     = 12;
  localparam int V_WIDTH     = 12;

  localparam int PIX_IDX_WIDTH = H_WIDTH + V_WIDTH;

  // Two bursts of buffering.
  localparam int FIFO_DEPTH  = 256;
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
  localparam int COUNT_WIDTH = FIFO_AW + 1;

  typedef struct packed {
    logic [H_WIDTH-1:0]                    h_visible;
    logic [V_WIDTH-1:0]                    v_visible;
    logic [axi_rd_pkg::AXI_ADDR_WIDTH-1:0] base;  // Byte address of pixel 0,0.
  } fb_geom_t;

  typedef struct packed {
    logic                   sof;
    logic                   eol;
    logic [COLOR_WIDTH-1:0] red;
    logic [COLOR_WIDTH-1:0] grn;
    logic [COLOR_WIDTH-1:0] blu;
  } pix_t;

endpackage

/* design/fb_line_fifo.sv */
`timescale 1ns/1ps

module fb_line_fifo (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  r_valid,
  input  axi_rd_pkg::axi_r_t                    r,
  output logic                                  r_ready,
  output logic                                  fifo_valid,
  output logic [axi_rd_pkg::AXI_DATA_WIDTH-1:0] fifo_data,
  input  logic                                  fifo_pop,
  output logic                                  pop
);
  import fb_cfg_pkg::*;
  import axi_rd_pkg::*;

  logic [AXI_DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]        wr_ptr;
  logic [FIFO_AW-1:0]        rd_ptr;
  logic [COUNT_WIDTH-1:0]    count;
  logic                      push;

  assign r_ready    = (count != COUNT_WIDTH'(FIFO_DEPTH));
  assign push       = r_valid && r_ready;
  assign fifo_valid = (count != '0);
  assign pop        = fifo_valid && fifo_pop;  // Also the credit return.
  assign fifo_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= r.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* design/fb_pix_unpack.sv */
`timescale 1ns/1ps

module fb_pix_unpack (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  fb_cfg_pkg::fb_geom_t                  geom,
  input  logic                                  fifo_valid,
  input  logic [axi_rd_pkg::AXI_DATA_WIDTH-1:0] fifo_data,
  output logic                                  fifo_pop,
  output logic                                  pix_valid,
  output fb_cfg_pkg::pix_t                      pix,
  input  logic                                  pix_ready
);
  import fb_cfg_pkg::*;
  import axi_rd_pkg::*;

  typedef struct packed {
    logic [AXI_DATA_WIDTH-3*COLOR_WIDTH-1:0] pad;
    logic [COLOR_WIDTH-1:0]                  red;
    logic [COLOR_WIDTH-1:0]                  grn;
    logic [COLOR_WIDTH-1:0]                  blu;
  } word_t;

  word_t              word;
  logic [H_WIDTH-1:0] h_cnt;
  logic [V_WIDTH-1:0] v_cnt;
  logic               take;
  logic               last_col;

  assign word     = word_t'(fifo_data);
  assign fifo_pop = !pix_valid || pix_ready;  // Stage empty or draining.
  assign take     = fifo_valid && fifo_pop;
  assign last_col = (h_cnt == geom.h_visible - 1'b1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pix_valid <= 1'b0;
      h_cnt     <= '0;
      v_cnt     <= '0;
    end else if (take) begin
      pix_valid <= 1'b1;
      h_cnt     <= last_col ? '0 : h_cnt + 1'b1;
      if (last_col) begin
        v_cnt <= (v_cnt == geom.v_visible - 1'b1) ? '0 : v_cnt + 1'b1;
      end
    end else if (pix_ready) begin
      pix_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pix.sof <= (h_cnt == '0) && (v_cnt == '0);
      pix.eol <= last_col;
      pix.red <= word.red;
      pix.grn <= word.grn;
      pix.blu <= word.blu;
    end
  end

endmodule

/* design/fb_sys.sv */
`timescale 1ns/1ps

module fb_sys (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable,
  input  fb_cfg_pkg::fb_geom_t  geom,
  input  axi_rd_pkg::mem_load_t load,
  output logic                  pix_valid,
  output fb_cfg_pkg::pix_t      pix,
  input  logic                  pix_ready
);
  import axi_rd_pkg::*;

  logic                      ar_valid;
  axi_ar_t                   ar;
  logic                      ar_ready;
  logic                      r_valid;
  axi_r_t                    r;
  logic                      r_ready;
  logic                      fifo_valid;
  logic [AXI_DATA_WIDTH-1:0] fifo_data;
  logic                      fifo_pop;
  logic                      pop;

  fb_burst_reader i_reader (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .geom     (geom),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .pop      (pop)
  );

  fb_line_fifo i_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .r_valid    (r_valid),
    .r          (r),
    .r_ready    (r_ready),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop),
    .pop        (pop)
  );

  fb_pix_unpack i_unpack (
    .clk        (clk),
    .rst_n      (rst_n),
    .geom       (geom),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop),
    .pix_valid  (pix_valid),
    .pix        (pix),
    .pix_ready  (pix_ready)
  );

  axi_rd_mem i_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready)
  );

endmodule

/* src.f */
design/axi_rd_pkg.sv
design/fb_cfg_pkg.sv
design/fb_burst_reader.sv
design/fb_line_fifo.sv
design/fb_pix_unpack.sv
design/axi_rd_mem.sv
design/fb_sys.sv
verification/fb_sys_props.sv
verification/fb_sys_tb.sv

/* verification/fb_sys_props.sv */
`timescale 1ns/1ps

module fb_sys_props (
  input logic                 clk,
  input logic                 rst_n,
  input fb_cfg_pkg::fb_geom_t geom,
  input logic                 ar_valid,
  input axi_rd_pkg::axi_ar_t  ar,
  input logic                 ar_ready,
  input logic                 r_valid,
  input axi_rd_pkg::axi_r_t   r,
  input logic                 r_ready,
  input logic                 pix_valid,
  input fb_cfg_pkg::pix_t     pix,
  input logic                 pix_ready
);
  import axi_rd_pkg::*;

  int unsigned fail_count = 0;
  logic [7:0]  beat;
  logic [7:0]  len_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat <= '0;
    end else if (r_valid && r_ready) begin
      beat <= r.last ? 8'd0 : beat + 8'd1;  // Position in burst.
    end
  end

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      len_q <= ar.len;
    end
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
      fail_count++;
      $error("AR request changed or dropped before acceptance");
    end

  ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid |-> ((ar.addr - geom.base) & AXI_ADDR_WIDTH'(2 * BURST_LEN - 1)) == '0)
    else begin
      fail_count++;
      $error("AR address not on a burst boundary from base");
    end

  pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix))
    else begin
      fail_count++;
      $error("Pixel changed or dropped while stalled");
    end

  r_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid |-> (r.last == (beat == len_q)))
    else begin
      fail_count++;
      $error("r_last does not match the final beat");
    end

endmodule

bind fb_sys fb_sys_props i_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .geom      (geom),
  .ar_valid  (ar_valid),
  .ar        (ar),
  .ar_ready  (ar_ready),
  .r_valid   (r_valid),
  .r         (r),
  .r_ready   (r_ready),
  .pix_valid (pix_valid),
  .pix       (pix),
  .pix_ready (pix_ready)
);

/* verification/fb_sys_tb.sv */
`timescale 1ns/1ps

module fb_sys_tb;
  import fb_cfg_pkg::*;
  import axi_rd_pkg::*;

  typedef struct {
    string                     name;
    int                        h;
    int                        v;
    logic [AXI_ADDR_WIDTH-1:0] base;
    int                        frames;
    int                        duty;  // Percent of cycles with pix_ready high.
  } row_t;

  localparam int NUM_ROWS = 4;

  row_t rows [NUM_ROWS] = '{
    '{"frame_256x3", 256, 3, 20'h0_0000, 2, 100},
    '{"stall_128x4", 128, 4, 20'h0_4200, 2, 30},
    '{"geom_128x2",  128, 2, 20'h1_0000, 3, 100},
    '{"geom_384x2",  384, 2, 20'h2_0100, 2, 60}
  };

  logic      clk = 1'b0;
  logic      rst_n;
  logic      enable;
  fb_geom_t  geom;
  mem_load_t load;
  logic      pix_valid;
  pix_t      pix;
  logic      pix_ready;

  logic [31:0]               rnd_state = 32'h1c92_1c69;
  logic [AXI_DATA_WIDTH-1:0] image [$];  // Copy of the loaded frame.
  string                     test_name;
  int                        pix_num;
  int                        errors = 0;
  int                        checked = 0;

  fb_sys i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .geom      (geom),
    .load      (load),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_value(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("** Error %s: %s at pixel %0d, expected %0h, actual %0h",
               test_name, field, pix_num, exp, act);
    end
  endtask

  task automatic load_image(input row_t row);
    int                        n;
    logic [AXI_DATA_WIDTH-1:0] word;
    n = row.h * row.v;
    image.delete();
    for (int i = 0; i < n; i++) begin
      rnd_state = next_rand(rnd_state);
      word = rnd_state[AXI_DATA_WIDTH-1:0];
      image.push_back(word);
      @(posedge clk);
      load <= '{we: 1'b1,
                addr: (AXI_ADDR_WIDTH-1)'(row.base[AXI_ADDR_WIDTH-1:1] + i),
                data: word};
    end
    @(posedge clk);
    load <= '0;
  endtask

  task automatic run_row(input row_t row);
    int                        frame_pix;
    int                        total;
    int                        p;
    logic [AXI_DATA_WIDTH-1:0] word;
    test_name = row.name;
    frame_pix = row.h * row.v;
    total     = frame_pix * row.frames;
    pix_num   = 0;
    load_image(row);
    @(posedge clk);
    rst_n     <= 1'b0;
    geom      <= '{h_visible: H_WIDTH'(row.h), v_visible: V_WIDTH'(row.v), base: row.base};
    pix_ready <= 1'b1;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Nothing may come out before enable.
    repeat (8) begin
      @(negedge clk);
      compare_value("idle pix_valid", 0, pix_valid);
    end
    @(posedge clk);
    enable <= 1'b1;
    while (pix_num < total) begin
      @(negedge clk);
      if (pix_valid && pix_ready) begin
        p    = pix_num % frame_pix;
        word = image[p];
        compare_value("sof", p == 0, pix.sof);
        compare_value("eol", (p % row.h) == row.h - 1, pix.eol);
        compare_value("red", word[11:8], pix.red);
        compare_value("grn", word[7:4], pix.grn);
        compare_value("blu", word[3:0], pix.blu);
        pix_num++;
        checked++;
      end
      @(posedge clk);
      rnd_state = next_rand(rnd_state);
      pix_ready <= (rnd_state % 100) < row.duty;
    end
    enable    <= 1'b0;
    pix_ready <= 1'b0;
  endtask

  initial begin
    rst_n     = 1'b0;
    enable    = 1'b0;
    geom      = '0;
    load      = '0;
    pix_ready = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("Checked %0d pixels: %0d data errors, %0d assertion failures",
             checked, errors, i_dut.i_props.fail_count);
    if (errors == 0 && i_dut.i_props.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Four cycles per pixel plus setup slack.
  initial begin
    int limit;
    limit = 2000;
    foreach (rows[i]) begin
      limit += rows[i].h * rows[i].v * rows[i].frames * 4;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the pixel stream did not complete within %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
